//--- Makefile
# Verilator build and run of the level-two trigger testbench

VERILATOR ?= verilator
TB_TOP    ?= tb_pueo_leveltwo
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TB_TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- dv/l2_model.svh
// reference model of the trigger pipeline, included inside the testbench module
// step_model reads the testbench drive signals at every rising clock edge

// stretch stage, current and previous nibbles per polarization and sector
logic [3:0] ref_low_cur [`L2_NPOL][`L2_NSECT];
logic [3:0] ref_low_prev [`L2_NPOL][`L2_NSECT];
logic [3:0] ref_high_cur [`L2_NPOL][`L2_NSECT];
logic [3:0] ref_high_prev [`L2_NPOL][`L2_NSECT];
logic [3:0] ref_coinc [`L2_NPOL][`L2_NSECT];
logic [`L2_NPOL-1:0] ref_l2;
logic [`L2_NPOL*`L2_NSECT-1:0] ref_hit;
logic [`L2_NPOL*`L2_NSECT-1:0] ref_hit_d;
logic [`L2_NPOL*`L2_NSECT-1:0] ref_lvl;
// aux and lf, captured then delayed two ce samples
logic ref_aux_cap;
logic [1:0] ref_aux_sh;
logic [1:0] ref_lf_cap;
logic [1:0] ref_lf_sh [2];
logic [`L2_NTIO-1:0][`L2_META_W-1:0] ref_meta [`L2_META_DEPTH];
logic ref_trig;

// hpol reads links 0 then 1, vpol reads links 3 then 2
function automatic int src_link(input int pol, input int sect);
    int half;
    half = sect / `L2_NSLOT;
    return (pol == 0) ? half : 3 - half;
endfunction

function automatic int src_slot(input int sect);
    return (sect < `L2_NSLOT) ? (`L2_NSLOT - 1 - sect) : (sect - `L2_NSLOT);
endfunction

// slot k holds its low nibble at bits 8k+3:8k and the high nibble just above
function automatic logic [3:0] nibble_of(input logic [63:0] word, input int slot,
                                         input int high);
    return word[8*slot + 4*high +: 4];
endfunction

task automatic reset_model();
    for (int p = 0; p < `L2_NPOL; p++) begin
        for (int s = 0; s < `L2_NSECT; s++) begin
            ref_low_cur[p][s] = '0;
            ref_low_prev[p][s] = '0;
            ref_high_cur[p][s] = '0;
            ref_high_prev[p][s] = '0;
            ref_coinc[p][s] = '0;
        end
    end
    ref_l2 = '0;
    ref_hit = '0;
    ref_hit_d = '0;
    ref_lvl = '0;
    ref_aux_cap = 1'b0;
    ref_aux_sh = '0;
    ref_lf_cap = '0;
    ref_lf_sh[0] = '0;
    ref_lf_sh[1] = '0;
    ref_trig = 1'b0;
    for (int d = 0; d < `L2_META_DEPTH; d++) begin
        ref_meta[d] = '0;
    end
endtask

task automatic step_model();
    logic [3:0] low_str [`L2_NPOL][`L2_NSECT];
    logic [3:0] high_str [`L2_NPOL][`L2_NSECT];
    logic [`L2_NPOL*`L2_NSECT-1:0] any_now;
    logic fire;
    fire = ref_aux_sh[1] || (|ref_lf_sh[1]) || (|ref_l2);
    if (rst_i) begin
        reset_model();
    end else begin
        // master register sees every clock, the rest only ce samples
        ref_trig = ce_i && !holdoff_i && !dead_i && fire;
        if (ce_i) begin
            ref_lvl = ref_hit & ~ref_hit_d;
            ref_hit_d = ref_hit;
            for (int p = 0; p < `L2_NPOL; p++) begin
                for (int s = 0; s < `L2_NSECT; s++) begin
                    any_now[`L2_NSECT*p + s] = |ref_coinc[p][s];
                    low_str[p][s] = ref_low_cur[p][s] | ref_low_prev[p][s];
                    high_str[p][s] = ref_high_cur[p][s] | ref_high_prev[p][s];
                end
            end
            ref_hit = any_now;
            for (int p = 0; p < `L2_NPOL; p++) begin
                ref_l2[p] = rf_en_i &&
                    (|(any_now[`L2_NSECT*p +: `L2_NSECT] & ~mask_i[`L2_NSECT*p +: `L2_NSECT]));
                for (int s = 0; s < `L2_NSECT; s++) begin
                    // low half of sector s meets the high half of sector s+1
                    ref_coinc[p][s] = logictype_i ?
                        (low_str[p][s] | high_str[p][(s + 1) % `L2_NSECT]) :
                        (low_str[p][s] & high_str[p][(s + 1) % `L2_NSECT]);
                    ref_low_prev[p][s] = ref_low_cur[p][s];
                    ref_high_prev[p][s] = ref_high_cur[p][s];
                    ref_low_cur[p][s] = nibble_of(meta_word[src_link(p, s)], src_slot(s), 0);
                    ref_high_cur[p][s] = nibble_of(meta_word[src_link(p, s)], src_slot(s), 1);
                end
            end
            ref_aux_sh = {ref_aux_sh[0], ref_aux_cap};
            ref_aux_cap = trig_word[0][`L2_AUX_BIT] | trig_word[1][`L2_AUX_BIT] |
                          trig_word[2][`L2_AUX_BIT] | trig_word[3][`L2_AUX_BIT];
            ref_lf_sh[1] = ref_lf_sh[0];
            ref_lf_sh[0] = ref_lf_cap;
            ref_lf_cap[0] = (trig_word[0][`L2_LF_BIT] | trig_word[2][`L2_LF_BIT]) &
                            rf_en_i & ~mask_i[`L2_LF_MASK0];
            ref_lf_cap[1] = (trig_word[1][`L2_LF_BIT] | trig_word[3][`L2_LF_BIT]) &
                            rf_en_i & ~mask_i[`L2_LF_MASK1];
            for (int d = `L2_META_DEPTH - 1; d > 0; d--) begin
                ref_meta[d] = ref_meta[d-1];
            end
            ref_meta[0] = meta_word;
        end
    end
endtask

//--- dv/tb_pueo_leveltwo.sv
`timescale 1ns/1ps

`include "l2_macros.svh"

module tb_pueo_leveltwo;

    localparam int CLK_HALF = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 16;
    localparam int NPHASE = 4;
    localparam int PHASE_CYCLES = 2000;
    // controls are redrawn this often inside a phase
    localparam int CTRL_HOLD = 500;
    // all phases plus a quarter of margin
    localparam int TIMEOUT_CYCLES = NPHASE * PHASE_CYCLES * 5 / 4;
    localparam logic [31:0] LFSR_SEED = 32'h762df378;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic clk_i;
    logic rst_i;
    logic ce_i;
    logic logictype_i;
    logic rf_en_i;
    logic holdoff_i;
    logic dead_i;
    logic [`L2_NTIO-1:0][`L2_TRIG_W-1:0] trig_word;
    logic [`L2_NTIO-1:0][`L2_META_W-1:0] meta_word;
    logic [`L2_MASK_W-1:0] mask_i;
    logic [`L2_NTIO-1:0][`L2_META_W-1:0] meta_out;
    logic [`L2_NPOL*`L2_NSECT-1:0] leveltwo_o;
    logic trig_o;

    logic [31:0] lfsr_state;
    int cycle_count = 0;
    logic trig_prev;
    int trig_pulses;
    int scaler_pulses;

    `include "l2_model.svh"

    pueo_leveltwo dut_i (
        .clk_i(clk_i), .rst_i(rst_i), .ce_i(ce_i), .logictype_i(logictype_i),
        .rf_en_i(rf_en_i), .holdoff_i(holdoff_i), .dead_i(dead_i),
        .tio0_trig_i(trig_word[0]), .tio1_trig_i(trig_word[1]),
        .tio2_trig_i(trig_word[2]), .tio3_trig_i(trig_word[3]),
        .tio0_meta_i(meta_word[0]), .tio1_meta_i(meta_word[1]),
        .tio2_meta_i(meta_word[2]), .tio3_meta_i(meta_word[3]),
        .mask_i(mask_i),
        .tio0_meta_o(meta_out[0]), .tio1_meta_o(meta_out[1]),
        .tio2_meta_o(meta_out[2]), .tio3_meta_o(meta_out[3]),
        .leveltwo_o(leveltwo_o), .trig_o(trig_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_HALF) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Checks failed");
            $fatal(1, "run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // each mask bit set with odds of one in four
    task automatic draw_mask(output logic [`L2_MASK_W-1:0] m);
        logic [63:0] r;
        for (int b = 0; b < `L2_MASK_W; b++) begin
            take_bits(2, r);
            m[b] = (r[1:0] == 2'b11);
        end
    endtask

    task automatic set_controls(input int ph, input int i);
        logic [`L2_MASK_W-1:0] m;
        draw_mask(m);
        rf_en_i = 1'b1;
        mask_i = m;
        case (ph)
            0: logictype_i = 1'b0;
            1: begin
                // vpol and both lf triggers fully masked
                logictype_i = 1'b1;
                mask_i[`L2_NPOL*`L2_NSECT-1:`L2_NSECT] = '1;
                mask_i[`L2_LF_MASK1:`L2_LF_MASK0] = 2'b11;
            end
            2: begin
                // rf off, then everything masked, so only aux can fire
                logictype_i = m[0];
                if (i < PHASE_CYCLES / 2) begin
                    rf_en_i = 1'b0;
                end else begin
                    mask_i = '1;
                end
            end
            default: begin
                logictype_i = 1'b1;
                if (i < PHASE_CYCLES / 2) begin
                    mask_i = '1;
                end
            end
        endcase
    endtask

    task automatic drive_inputs(input int ph, input int i);
        logic [63:0] r;
        if (i % CTRL_HOLD == 0) begin
            set_controls(ph, i);
        end
        take_bits(3, r);
        // ce never on two clocks in a row, close to every other clock
        ce_i = !ce_i && (r[2:0] != 3'b000);
        for (int t = 0; t < `L2_NTIO; t++) begin
            // sparse nibble bits, about one in eight
            for (int b = 0; b < `L2_META_W; b++) begin
                take_bits(3, r);
                meta_word[t][b] = (r[2:0] == 3'b111);
            end
            take_bits(6, r);
            trig_word[t][5:0] = r[5:0];
            take_bits(6, r);
            trig_word[t][`L2_LF_BIT] = (r[5:0] == 6'h3f);
            take_bits(6, r);
            trig_word[t][`L2_AUX_BIT] = (r[5:0] == 6'h3f);
        end
        // short, rare stretches of holdoff and dead time
        take_bits(5, r);
        holdoff_i = holdoff_i ? (r[1:0] != 2'b11) : (r[4:0] == 5'h1f);
        take_bits(5, r);
        dead_i = dead_i ? (r[1:0] != 2'b11) : (r[4:0] == 5'h1f);
    endtask

    task automatic check_outputs();
        check_value("trig_o", 64'(trig_o), 64'(ref_trig));
        check_value("leveltwo_o", 64'(leveltwo_o), 64'(ref_lvl));
        for (int t = 0; t < `L2_NTIO; t++) begin
            check_value($sformatf("tio%0d_meta_o", t), meta_out[t],
                        ref_meta[`L2_META_DEPTH-1][t]);
        end
        // a master trigger lasts exactly one clock
        check_value("trig_o on two clocks", 64'(trig_o && trig_prev), 64'd0);
        trig_prev = trig_o;
        if (trig_o) begin
            trig_pulses++;
        end
        if (|leveltwo_o) begin
            scaler_pulses++;
        end
    endtask

    task automatic run_cycle();
        @(posedge clk_i);
        step_model();
        #(DRIVE_DELAY);
        check_outputs();
    endtask

    initial begin
        lfsr_state = LFSR_SEED;
        rst_i = 1'b1;
        ce_i = 1'b0;
        logictype_i = 1'b0;
        rf_en_i = 1'b0;
        holdoff_i = 1'b0;
        dead_i = 1'b0;
        trig_word = '0;
        meta_word = '0;
        mask_i = '0;
        trig_prev = 1'b0;
        scaler_pulses = 0;
        reset_model();
        repeat (RESET_CYCLES) begin
            run_cycle();
        end
        rst_i = 1'b0;
        for (int ph = 0; ph < NPHASE; ph++) begin
            trig_pulses = 0;
            for (int i = 0; i < PHASE_CYCLES; i++) begin
                drive_inputs(ph, i);
                run_cycle();
            end
            if (trig_pulses == 0) begin
                $display("Checks failed");
                $fatal(1, "phase %0d never produced a master trigger", ph);
            end
        end
        if (scaler_pulses == 0) begin
            $display("Checks failed");
            $fatal(1, "no sector scaler pulse was seen during the run");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

//--- filelist.f
+incdir+src
+incdir+dv
src/tio_pkg.sv
src/l2_pkg.sv
src/l2_sector_stretch.sv
src/l2_coincidence.sv
src/l2_sector_trigger.sv
src/l2_trigger_merge.sv
src/l2_meta_delay.sv
src/pueo_leveltwo.sv
dv/tb_pueo_leveltwo.sv

//--- src/l2_coincidence.sv
`timescale 1ns/1ps

`include "l2_macros.svh"

module l2_coincidence (
    input  logic                                            clk_i,
    input  logic                                            rst_i,
    input  logic                                            ce_i,
    input  logic                                            logictype_i,
    input  logic [`L2_NPOL-1:0][l2_pkg::L2_SECT_BITS-1:0]   low_str_i,
    input  logic [`L2_NPOL-1:0][l2_pkg::L2_SECT_BITS-1:0]   high_str_i,
    output logic [`L2_NPOL-1:0][l2_pkg::L2_SECT_BITS-1:0]   coinc_o
);
    import l2_pkg::*;

    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0] high_rot;
    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0] pair;

    always_comb begin
        for (int p = 0; p < `L2_NPOL; p++) begin
            // sector s lines up with the high half of sector s+1, 11 wraps to 0
            high_rot[p] = {high_str_i[p][`L2_NREGION-1:0],
                           high_str_i[p][L2_SECT_BITS-1:`L2_NREGION]};
            // 0 selects and, 1 selects or
            if (logictype_i) begin
                pair[p] = low_str_i[p] | high_rot[p];
            end else begin
                pair[p] = low_str_i[p] & high_rot[p];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            coinc_o <= '0;
        end else if (ce_i) begin
            coinc_o <= pair;
        end
    end

endmodule

//--- src/l2_macros.svh
`ifndef L2_MACROS_SVH
`define L2_MACROS_SVH

// polarizations, index 0 is hpol and index 1 is vpol
`define L2_NPOL 2
// surf sectors per polarization
`define L2_NSECT 12
// regions per sector, also the nibble width
`define L2_NREGION 4
// turfio links
`define L2_NTIO 4
`define L2_META_W 64
`define L2_TRIG_W 8
// used slots on each link
`define L2_NSLOT 6

// trigger word bit positions
`define L2_AUX_BIT 7
`define L2_LF_BIT 6

// mask word, bits 24 and 25 are reserved
`define L2_MASK_W 28
`define L2_LF_MASK0 26
`define L2_LF_MASK1 27

// ce samples from input capture to the registered level-two trigger
`define L2_RF_DEPTH 3
`define L2_META_DEPTH 4

`endif

//--- src/l2_meta_delay.sv
`timescale 1ns/1ps

`include "l2_macros.svh"

module l2_meta_delay (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                ce_i,
    input  tio_pkg::tio_meta_u [`L2_NTIO-1:0]   meta_i,
    output logic [`L2_NTIO-1:0][`L2_META_W-1:0] meta_o
);
    logic [`L2_META_DEPTH-1:0][`L2_NTIO-1:0][`L2_META_W-1:0] stage;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage <= '0;
        end else if (ce_i) begin
            for (int t = 0; t < `L2_NTIO; t++) begin
                stage[0][t] <= meta_i[t].raw;
            end
            for (int d = 1; d < `L2_META_DEPTH; d++) begin
                stage[d] <= stage[d-1];
            end
        end
    end

    // last stage leaves together with the master trigger
    assign meta_o = stage[`L2_META_DEPTH-1];

endmodule

//--- src/l2_pkg.sv
`include "l2_macros.svh"

package l2_pkg;

    localparam int unsigned L2_HPOL = 0;
    localparam int unsigned L2_VPOL = 1;

    // one bit per region across all sectors of a polarization
    localparam int unsigned L2_SECT_BITS = `L2_NSECT * `L2_NREGION;

    // hpol uses links 0 and 1, vpol uses links 3 and 2
    function automatic int unsigned sector_tio(input int unsigned pol,
                                               input int unsigned sector);
        int unsigned left_half;
        left_half = (sector < `L2_NSLOT) ? 1 : 0;
        if (pol == L2_HPOL) begin
            return (left_half != 0) ? 0 : 1;
        end
        return (left_half != 0) ? 3 : 2;
    endfunction

    // left sectors run backwards through the slots
    function automatic int unsigned sector_slot(input int unsigned sector);
        if (sector < `L2_NSLOT) begin
            return `L2_NSLOT - 1 - sector;
        end
        return sector - `L2_NSLOT;
    endfunction

endpackage

//--- src/l2_sector_stretch.sv
`timescale 1ns/1ps

`include "l2_macros.svh"

module l2_sector_stretch (
    input  logic                                            clk_i,
    input  logic                                            rst_i,
    input  logic                                            ce_i,
    input  tio_pkg::tio_meta_u [`L2_NTIO-1:0]               meta_i,
    output logic [`L2_NPOL-1:0][l2_pkg::L2_SECT_BITS-1:0]   low_str_o,
    output logic [`L2_NPOL-1:0][l2_pkg::L2_SECT_BITS-1:0]   high_str_o
);
    import tio_pkg::*;
    import l2_pkg::*;

    // metadata nibbles in sector order
    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0] low_in;
    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0] high_in;

    // current and previous ce samples
    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0] low_cur;
    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0] low_prev;
    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0] high_cur;
    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0] high_prev;

    always_comb begin
        for (int p = 0; p < `L2_NPOL; p++) begin
            for (int s = 0; s < `L2_NSECT; s++) begin
                low_in[p][`L2_NREGION*s +: `L2_NREGION] =
                    meta_i[sector_tio(p, s)].slot[sector_slot(s)][TIO_LOW_NIB];
                high_in[p][`L2_NREGION*s +: `L2_NREGION] =
                    meta_i[sector_tio(p, s)].slot[sector_slot(s)][TIO_HIGH_NIB];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            low_cur <= '0;
            low_prev <= '0;
            high_cur <= '0;
            high_prev <= '0;
        end else if (ce_i) begin
            low_cur <= low_in;
            low_prev <= low_cur;
            high_cur <= high_in;
            high_prev <= high_cur;
        end
    end

    // a nibble stays visible for two ce samples
    assign low_str_o = low_cur | low_prev;
    assign high_str_o = high_cur | high_prev;

endmodule

//--- src/l2_sector_trigger.sv
`timescale 1ns/1ps

`include "l2_macros.svh"

module l2_sector_trigger (
    input  logic                                            clk_i,
    input  logic                                            rst_i,
    input  logic                                            ce_i,
    input  logic                                            rf_en_i,
    input  logic [`L2_NPOL-1:0][l2_pkg::L2_SECT_BITS-1:0]   coinc_i,
    input  logic [`L2_NPOL*`L2_NSECT-1:0]                   mask_i,
    output logic [`L2_NPOL-1:0]                             l2_trig_o,
    output logic [`L2_NPOL*`L2_NSECT-1:0]                   leveltwo_o
);
    localparam int unsigned NSECT_ALL = `L2_NPOL * `L2_NSECT;

    // any region of a sector, mask not applied
    logic [NSECT_ALL-1:0] sect_any;
    logic [NSECT_ALL-1:0] sect_live;
    logic [`L2_NPOL-1:0]  pol_trig;

    // registered hits and the hits one ce sample before
    logic [NSECT_ALL-1:0] hit;
    logic [NSECT_ALL-1:0] hit_d;

    always_comb begin
        for (int p = 0; p < `L2_NPOL; p++) begin
            for (int s = 0; s < `L2_NSECT; s++) begin
                sect_any[`L2_NSECT*p + s] = |coinc_i[p][`L2_NREGION*s +: `L2_NREGION];
            end
        end
    end

    // a set mask bit removes the sector from the trigger only
    assign sect_live = sect_any & ~mask_i;

    always_comb begin
        for (int p = 0; p < `L2_NPOL; p++) begin
            pol_trig[p] = rf_en_i && (|sect_live[`L2_NSECT*p +: `L2_NSECT]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            l2_trig_o <= '0;
            hit <= '0;
            hit_d <= '0;
            leveltwo_o <= '0;
        end else if (ce_i) begin
            l2_trig_o <= pol_trig;
            hit <= sect_any;
            hit_d <= hit;
            // scaler pulse on a rising sector hit
            leveltwo_o <= hit & ~hit_d;
        end
    end

endmodule

//--- src/l2_trigger_merge.sv
`timescale 1ns/1ps

`include "l2_macros.svh"

module l2_trigger_merge (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                ce_i,
    input  logic                                rf_en_i,
    input  logic                                holdoff_i,
    input  logic                                dead_i,
    input  logic [`L2_NTIO-1:0][`L2_TRIG_W-1:0] trig_i,
    input  logic [1:0]                          lf_mask_i,
    input  logic [`L2_NPOL-1:0]                 l2_trig_i,
    output logic                                trig_o
);
    // ce samples between capture and the level-two trigger register
    localparam int unsigned ALIGN = `L2_RF_DEPTH - 1;

    logic [`L2_NTIO-1:0] aux_bits;
    logic                aux_cap;
    logic [1:0]          lf_cap;
    logic [ALIGN-1:0]    aux_sh;
    logic [ALIGN-1:0][1:0] lf_sh;
    logic                any_trig;

    always_comb begin
        for (int t = 0; t < `L2_NTIO; t++) begin
            aux_bits[t] = trig_i[t][`L2_AUX_BIT];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            aux_cap <= 1'b0;
            lf_cap <= '0;
            aux_sh <= '0;
            lf_sh <= '0;
        end else if (ce_i) begin
            aux_cap <= |aux_bits;
            // left lf from links 0 and 2, right lf from links 1 and 3
            lf_cap[0] <= (trig_i[0][`L2_LF_BIT] || trig_i[2][`L2_LF_BIT]) &&
                         rf_en_i && !lf_mask_i[0];
            lf_cap[1] <= (trig_i[1][`L2_LF_BIT] || trig_i[3][`L2_LF_BIT]) &&
                         rf_en_i && !lf_mask_i[1];
            aux_sh[0] <= aux_cap;
            lf_sh[0] <= lf_cap;
            for (int i = 1; i < ALIGN; i++) begin
                aux_sh[i] <= aux_sh[i-1];
                lf_sh[i] <= lf_sh[i-1];
            end
        end
    end

    assign any_trig = aux_sh[ALIGN-1] || (|lf_sh[ALIGN-1]) || (|l2_trig_i);

    // runs on every clock so the pulse lasts one clock
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            trig_o <= 1'b0;
        end else begin
            trig_o <= ce_i && !holdoff_i && !dead_i && any_trig;
        end
    end

endmodule

//--- src/pueo_leveltwo.sv
`timescale 1ns/1ps

`include "l2_macros.svh"

module pueo_leveltwo (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        ce_i,
    input  logic                        logictype_i,
    input  logic                        rf_en_i,
    input  logic                        holdoff_i,
    input  logic                        dead_i,
    input  logic [`L2_TRIG_W-1:0]       tio0_trig_i,
    input  logic [`L2_TRIG_W-1:0]       tio1_trig_i,
    input  logic [`L2_TRIG_W-1:0]       tio2_trig_i,
    input  logic [`L2_TRIG_W-1:0]       tio3_trig_i,
    input  logic [`L2_META_W-1:0]       tio0_meta_i,
    input  logic [`L2_META_W-1:0]       tio1_meta_i,
    input  logic [`L2_META_W-1:0]       tio2_meta_i,
    input  logic [`L2_META_W-1:0]       tio3_meta_i,
    input  logic [`L2_MASK_W-1:0]       mask_i,
    output logic [`L2_META_W-1:0]       tio0_meta_o,
    output logic [`L2_META_W-1:0]       tio1_meta_o,
    output logic [`L2_META_W-1:0]       tio2_meta_o,
    output logic [`L2_META_W-1:0]       tio3_meta_o,
    output logic [`L2_NPOL*`L2_NSECT-1:0] leveltwo_o,
    output logic                        trig_o
);
    import tio_pkg::*;
    import l2_pkg::*;

    tio_meta_u [`L2_NTIO-1:0]                meta_in;
    logic [`L2_NTIO-1:0][`L2_TRIG_W-1:0]     trig_in;
    logic [`L2_NTIO-1:0][`L2_META_W-1:0]     meta_out;
    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0]   low_str;
    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0]   high_str;
    logic [`L2_NPOL-1:0][L2_SECT_BITS-1:0]   coinc;
    logic [`L2_NPOL-1:0]                     l2_trig;

    assign meta_in[0].raw = tio0_meta_i;
    assign meta_in[1].raw = tio1_meta_i;
    assign meta_in[2].raw = tio2_meta_i;
    assign meta_in[3].raw = tio3_meta_i;
    assign trig_in = {tio3_trig_i, tio2_trig_i, tio1_trig_i, tio0_trig_i};

    l2_sector_stretch u_stretch (
        .clk_i(clk_i), .rst_i(rst_i), .ce_i(ce_i), .meta_i(meta_in),
        .low_str_o(low_str), .high_str_o(high_str)
    );

    l2_coincidence u_coinc (
        .clk_i(clk_i), .rst_i(rst_i), .ce_i(ce_i), .logictype_i(logictype_i),
        .low_str_i(low_str), .high_str_i(high_str), .coinc_o(coinc)
    );

    // low 24 mask bits are the sector masks
    l2_sector_trigger u_sector (
        .clk_i(clk_i), .rst_i(rst_i), .ce_i(ce_i), .rf_en_i(rf_en_i),
        .coinc_i(coinc), .mask_i(mask_i[`L2_NPOL*`L2_NSECT-1:0]),
        .l2_trig_o(l2_trig), .leveltwo_o(leveltwo_o)
    );

    l2_trigger_merge u_merge (
        .clk_i(clk_i), .rst_i(rst_i), .ce_i(ce_i), .rf_en_i(rf_en_i),
        .holdoff_i(holdoff_i), .dead_i(dead_i), .trig_i(trig_in),
        .lf_mask_i({mask_i[`L2_LF_MASK1], mask_i[`L2_LF_MASK0]}),
        .l2_trig_i(l2_trig), .trig_o(trig_o)
    );

    l2_meta_delay u_meta (
        .clk_i(clk_i), .rst_i(rst_i), .ce_i(ce_i), .meta_i(meta_in), .meta_o(meta_out)
    );

    assign tio0_meta_o = meta_out[0];
    assign tio1_meta_o = meta_out[1];
    assign tio2_meta_o = meta_out[2];
    assign tio3_meta_o = meta_out[3];

endmodule

//--- src/tio_pkg.sv
`include "l2_macros.svh"

package tio_pkg;

    // each slot carries a low and a high nibble
    localparam int unsigned TIO_NIBBLES = 2;
    localparam int unsigned TIO_SLOTS = `L2_META_W / (TIO_NIBBLES * `L2_NREGION);

    // nibble index inside a slot
    localparam int unsigned TIO_LOW_NIB = 0;
    localparam int unsigned TIO_HIGH_NIB = 1;

    // one metadata word from a link
    // raw travels through the delay line, slot feeds the sector map
    typedef union packed {
        logic [`L2_META_W-1:0] raw;
        logic [TIO_SLOTS-1:0][TIO_NIBBLES-1:0][`L2_NREGION-1:0] slot;
    } tio_meta_u;

endpackage
